// ==== rv_core_stim.txt ====
# I <address> <instruction word>
# R <pc> <rd> <data>, expected retires in order
I 00000000 800000B7
R 00000000 01 80000000
I 00000004 00500113
R 00000004 02 00000005
I 00000008 FFD00193
R 00000008 03 FFFFFFFD
I 0000000C 00310233
R 0000000C 04 00000002
I 00000010 403102B3
R 00000010 05 00000008
I 00000014 4020D333
R 00000014 06 FC000000
I 00000018 0020D3B3
R 00000018 07 04000000
I 0000001C 0020A433
R 0000001C 08 00000001
I 00000020 0020B4B3
R 00000020 09 00000000
I 00000024 0021C533
R 00000024 0A FFFFFFF8
I 00000028 005265B3
R 00000028 0B 0000000A
I 0000002C 00B1F633
R 0000002C 0C 00000008
I 00000030 002616B3
R 00000030 0D 00000100
I 00000034 7FF1C713
R 00000034 0E FFFFF802
I 00000038 4011D793
R 00000038 0F FFFFFFFE
I 0000003C FFF13813
R 0000003C 10 00000001
I 00000040 FFE1A893
R 00000040 11 00000001
I 00000044 12345917
R 00000044 12 12345044
# Unknown opcode, write to x0, then a read of x0
I 00000048 0000057F
R 00000048 00 00000000
I 0000004C 05500013
R 0000004C 00 00000000
I 00000050 00700993
R 00000050 13 00000007
# Taken branches jump over two slots
I 00000054 00210663
R 00000054 00 00000000
I 00000058 00100F93
I 0000005C 00100F93
I 00000060 00209663
R 00000060 00 00000000
I 0000006C 0020C663
R 0000006C 00 00000000
I 00000078 00115663
R 00000078 00 00000000
I 00000084 00116663
R 00000084 00 00000000
I 00000090 0020F663
R 00000090 00 00000000
I 0000009C 00208663
R 0000009C 00 00000000
I 000000A0 00198A13
R 000000A0 14 00000008
# JAL, JALR to an odd target, then the final self loop
I 000000A4 00C00AEF
R 000000A4 15 000000A8
I 000000B0 019A8B67
R 000000B0 16 000000B4
I 000000C0 015B0BB3
R 000000C0 17 0000015C
I 000000C4 0000006F
R 000000C4 00 00000000

// ==== sources.f ====
+incdir+.
rv_core_pkg.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
reg_file.sv
rv_core.sv
tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv_core_pkg.sv
      - fetch_unit.sv
      - decode_unit.sv
      - execute_unit.sv
      - reg_file.sv
      - rv_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_rv_core.sv

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module tb_rv_core;

    localparam int MEM_WORDS    = 256;
    localparam int MAX_RECORDS  = 128;
    localparam int RESET_CYCLES = 16;

    logic                clk;
    logic                rst_n_i;
    logic [`RV_XLEN-1:0] imem_addr_o;
    logic [`RV_XLEN-1:0] imem_data_i;
    logic                retire_valid_o;
    logic [`RV_XLEN-1:0] retire_pc_o;
    logic          [4:0] retire_rd_o;
    logic [`RV_XLEN-1:0] retire_data_o;

    // Program image, word addressed
    logic [`RV_XLEN-1:0] imem [MEM_WORDS];
    logic                imem_loaded [MEM_WORDS];

    // Expected retire stream in order
    logic [`RV_XLEN-1:0] exp_pc [MAX_RECORDS];
    logic          [4:0] exp_rd [MAX_RECORDS];
    logic [`RV_XLEN-1:0] exp_data [MAX_RECORDS];
    int                  num_records;
    int                  next_record;
    int                  cycle_count;
    int                  timeout_limit;

    rv_core rv_core_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .imem_addr_o    (imem_addr_o),
        .imem_data_i    (imem_data_i),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    always #2 clk = ~clk;

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [`RV_XLEN-1:0] expected,
                               input logic [`RV_XLEN-1:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("Mismatch in %s: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    // Unloaded or out of range addresses read as NOP
    function automatic logic [`RV_XLEN-1:0] fetch_word(input logic [`RV_XLEN-1:0] addr);
        logic [`RV_XLEN-1:0] index;
        index = addr >> 2;
        if (index < MEM_WORDS && imem_loaded[index]) begin
            return imem[index];
        end
        return `RV_NOP;
    endfunction

    task automatic load_stimulus();
        int                  fd;
        int                  n;
        int                  i;
        logic [8*8-1:0]      tag;
        logic [8*160-1:0]    rest;
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] b;
        logic [`RV_XLEN-1:0] c;
        num_records = 0;
        for (i = 0; i < MEM_WORDS; i++) begin
            imem_loaded[i] = 1'b0;
        end
        fd = $fopen("rv_core_stim.txt", "r");
        if (fd == 0) begin
            report_failure("Could not open the stimulus file rv_core_stim.txt");
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "#") begin
                    n = $fgets(rest, fd);
                end else if (tag == "I") begin
                    n = $fscanf(fd, "%h %h", a, b);
                    if (n != 2 || (a >> 2) >= MEM_WORDS) begin
                        report_failure("Bad instruction line in the stimulus file");
                    end else begin
                        imem[a >> 2]        = b;
                        imem_loaded[a >> 2] = 1'b1;
                    end
                end else if (tag == "R") begin
                    n = $fscanf(fd, "%h %h %h", a, b, c);
                    if (n != 3 || num_records >= MAX_RECORDS) begin
                        report_failure("Bad or surplus retire line in the stimulus file");
                    end else begin
                        exp_pc[num_records]   = a;
                        exp_rd[num_records]   = b[4:0];
                        exp_data[num_records] = c;
                        num_records++;
                    end
                end else begin
                    report_failure("Unknown line type in the stimulus file");
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_retire();
        string name;
        if (retire_valid_o === 1'b1) begin
            if (next_record >= num_records) begin
                report_failure($sformatf("Retire at pc %h came after all expected retires",
                                         retire_pc_o));
            end else begin
                name = $sformatf("retire %0d", next_record);
                check_value({name, " pc"}, exp_pc[next_record], retire_pc_o);
                check_value({name, " rd"}, {27'b0, exp_rd[next_record]}, {27'b0, retire_rd_o});
                check_value({name, " data"}, exp_data[next_record], retire_data_o);
                next_record++;
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        imem_data_i = `RV_NOP;
        next_record = 0;
        cycle_count = 0;
        load_stimulus();
        timeout_limit = RESET_CYCLES + 3 * num_records + 20;

        // Memory answers and retire checks happen 1 ns after each edge
        while (next_record < num_records && cycle_count < timeout_limit) begin
            @(posedge clk);
            #1;
            cycle_count++;
            if (cycle_count == RESET_CYCLES) begin
                rst_n_i = 1'b1;
            end
            check_retire();
            imem_data_i = fetch_word(imem_addr_o);
        end

        if (next_record == num_records) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            report_failure($sformatf("Timeout: only %0d of %0d expected retires arrived in %0d cycles",
                                     next_record, num_records, cycle_count));
        end
    end

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_core (
    input  wire logic                clk,
    input  wire logic                rst_n_i,
    output logic      [`RV_XLEN-1:0] imem_addr_o,
    input  wire logic [`RV_XLEN-1:0] imem_data_i,
    output logic                     retire_valid_o,
    output logic      [`RV_XLEN-1:0] retire_pc_o,
    output logic               [4:0] retire_rd_o,
    output logic      [`RV_XLEN-1:0] retire_data_o
);
    import rv_core_pkg::*;

    logic                f_valid;
    logic [`RV_XLEN-1:0] f_pc;
    instr_u              f_instr;
    logic          [4:0] rs1_addr, rs2_addr;
    logic [`RV_XLEN-1:0] rs1_data, rs2_data;
    logic                d_valid, d_wen;
    logic [`RV_XLEN-1:0] d_pc, d_rs1_data, d_rs2_data, d_imm;
    logic          [4:0] d_rs1_addr, d_rs2_addr, d_rd;
    alu_op_e             d_alu_op;
    src_a_e              d_src_a;
    src_b_e              d_src_b;
    br_cond_e            d_br;
    logic                redirect;
    logic [`RV_XLEN-1:0] target;
    logic                w_valid, w_wen;
    logic [`RV_XLEN-1:0] w_pc, w_data;
    logic          [4:0] w_rd;

    fetch_unit fetch_unit_i (
        .clk, .rst_n_i, .redirect_i(redirect), .target_i(target), .imem_addr_o,
        .imem_data_i(instr_u'(imem_data_i)), .f_valid_o(f_valid), .f_pc_o(f_pc),
        .f_instr_o(f_instr)
    );

    // A taken jump also empties decode
    decode_unit decode_unit_i (
        .clk, .rst_n_i, .flush_i(redirect), .f_valid_i(f_valid), .f_pc_i(f_pc),
        .f_instr_i(f_instr), .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .d_valid_o(d_valid), .d_pc_o(d_pc),
        .d_rs1_addr_o(d_rs1_addr), .d_rs2_addr_o(d_rs2_addr), .d_rs1_data_o(d_rs1_data),
        .d_rs2_data_o(d_rs2_data), .d_imm_o(d_imm), .d_rd_o(d_rd), .d_wen_o(d_wen),
        .d_alu_op_o(d_alu_op), .d_src_a_o(d_src_a), .d_src_b_o(d_src_b), .d_br_o(d_br)
    );

    execute_unit execute_unit_i (
        .clk, .rst_n_i, .d_valid_i(d_valid), .d_pc_i(d_pc), .d_rs1_addr_i(d_rs1_addr),
        .d_rs2_addr_i(d_rs2_addr), .d_rs1_data_i(d_rs1_data), .d_rs2_data_i(d_rs2_data),
        .d_imm_i(d_imm), .d_rd_i(d_rd), .d_wen_i(d_wen), .d_alu_op_i(d_alu_op),
        .d_src_a_i(d_src_a), .d_src_b_i(d_src_b), .d_br_i(d_br), .redirect_o(redirect),
        .target_o(target), .w_valid_o(w_valid), .w_pc_o(w_pc), .w_rd_o(w_rd),
        .w_wen_o(w_wen), .w_data_o(w_data)
    );

    reg_file reg_file_i (
        .clk, .rst_n_i, .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .w_valid_i(w_valid), .w_pc_i(w_pc),
        .w_rd_i(w_rd), .w_wen_i(w_wen), .w_data_i(w_data), .retire_valid_o,
        .retire_pc_o, .retire_rd_o, .retire_data_o
    );

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module reg_file (
    input  wire logic                clk,
    input  wire logic                rst_n_i,
    input  wire logic          [4:0] rs1_addr_i,
    input  wire logic          [4:0] rs2_addr_i,
    output logic      [`RV_XLEN-1:0] rs1_data_o,
    output logic      [`RV_XLEN-1:0] rs2_data_o,
    input  wire logic                w_valid_i,
    input  wire logic [`RV_XLEN-1:0] w_pc_i,
    input  wire logic          [4:0] w_rd_i,
    input  wire logic                w_wen_i,
    input  wire logic [`RV_XLEN-1:0] w_data_i,
    output logic                     retire_valid_o,
    output logic      [`RV_XLEN-1:0] retire_pc_o,
    output logic               [4:0] retire_rd_o,
    output logic      [`RV_XLEN-1:0] retire_data_o
);
    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0] regs_q [1:`RV_NREGS-1];
    logic                wr_en;

    assign wr_en = w_valid_i && w_wen_i;

    // x0 reads as zero and a same-cycle write passes through
    assign rs1_data_o = (rs1_addr_i == 5'd0)               ? '0 :
                        (wr_en && w_rd_i == rs1_addr_i)    ? w_data_i :
                                                             regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0)               ? '0 :
                        (wr_en && w_rd_i == rs2_addr_i)    ? w_data_i :
                                                             regs_q[rs2_addr_i];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[w_rd_i] <= w_data_i;
        end
    end

    assign retire_valid_o = w_valid_i;
    assign retire_pc_o    = w_pc_i;
    assign retire_rd_o    = wr_en ? w_rd_i : 5'd0;
    assign retire_data_o  = wr_en ? w_data_i : '0;

endmodule

`default_nettype wire

// ==== execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module execute_unit (
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,
    input  wire logic                  d_valid_i,
    input  wire logic   [`RV_XLEN-1:0] d_pc_i,
    input  wire logic            [4:0] d_rs1_addr_i,
    input  wire logic            [4:0] d_rs2_addr_i,
    input  wire logic   [`RV_XLEN-1:0] d_rs1_data_i,
    input  wire logic   [`RV_XLEN-1:0] d_rs2_data_i,
    input  wire logic   [`RV_XLEN-1:0] d_imm_i,
    input  wire logic            [4:0] d_rd_i,
    input  wire logic                  d_wen_i,
    input  wire rv_core_pkg::alu_op_e  d_alu_op_i,
    input  wire rv_core_pkg::src_a_e   d_src_a_i,
    input  wire rv_core_pkg::src_b_e   d_src_b_i,
    input  wire rv_core_pkg::br_cond_e d_br_i,
    output logic                       redirect_o,
    output logic        [`RV_XLEN-1:0] target_o,
    output logic                       w_valid_o,
    output logic        [`RV_XLEN-1:0] w_pc_o,
    output logic                 [4:0] w_rd_o,
    output logic                       w_wen_o,
    output logic        [`RV_XLEN-1:0] w_data_o
);
    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0] rs1_val, rs2_val;
    logic [`RV_XLEN-1:0] op_a, op_b;
    logic [`RV_XLEN-1:0] alu_res, jalr_sum, result;
    logic                taken;

    // w_wen_o is never set for x0, so a match means a real write
    assign rs1_val = (w_wen_o && w_rd_o == d_rs1_addr_i) ? w_data_o : d_rs1_data_i;
    assign rs2_val = (w_wen_o && w_rd_o == d_rs2_addr_i) ? w_data_o : d_rs2_data_i;

    always_comb begin
        case (d_src_a_i)
            SRC_A_RS1: op_a = rs1_val;
            SRC_A_PC:  op_a = d_pc_i;
            default:   op_a = '0;
        endcase
        op_b = (d_src_b_i == SRC_B_RS2) ? rs2_val : d_imm_i;
    end

    always_comb begin
        case (d_alu_op_i)
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_AND:  alu_res = op_a & op_b;
            ALU_OR:   alu_res = op_a | op_b;
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SLL:  alu_res = op_a << op_b[4:0];
            ALU_SRL:  alu_res = op_a >> op_b[4:0];
            ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
            ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            default:  alu_res = op_a + op_b;
        endcase
    end

    // Branch compare always sees the register operands
    always_comb begin
        case (d_br_i)
            BR_EQ:           taken = (rs1_val == rs2_val);
            BR_NE:           taken = (rs1_val != rs2_val);
            BR_LT:           taken = ($signed(rs1_val) < $signed(rs2_val));
            BR_GE:           taken = ($signed(rs1_val) >= $signed(rs2_val));
            BR_LTU:          taken = (rs1_val < rs2_val);
            BR_GEU:          taken = (rs1_val >= rs2_val);
            BR_JAL, BR_JALR: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    assign jalr_sum   = rs1_val + d_imm_i;
    assign target_o   = (d_br_i == BR_JALR) ? {jalr_sum[`RV_XLEN-1:1], 1'b0} : d_pc_i + d_imm_i;
    assign redirect_o = d_valid_i && taken;

    // Jumps link pc+4
    assign result = (d_br_i == BR_JAL || d_br_i == BR_JALR) ? d_pc_i + 4 : alu_res;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            w_valid_o <= 1'b0;
            w_wen_o   <= 1'b0;
        end else begin
            w_valid_o <= d_valid_i;
            w_wen_o   <= d_valid_i && d_wen_i && (d_rd_i != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        w_pc_o   <= d_pc_i;
        w_rd_o   <= d_rd_i;
        w_data_o <= result;
    end

endmodule

`default_nettype wire

// ==== decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module decode_unit (
    input  wire logic                 clk,
    input  wire logic                 rst_n_i,
    input  wire logic                 flush_i,
    input  wire logic                 f_valid_i,
    input  wire logic  [`RV_XLEN-1:0] f_pc_i,
    input  wire rv_core_pkg::instr_u  f_instr_i,
    output logic                [4:0] rs1_addr_o,
    output logic                [4:0] rs2_addr_o,
    input  wire logic  [`RV_XLEN-1:0] rs1_data_i,
    input  wire logic  [`RV_XLEN-1:0] rs2_data_i,
    output logic                      d_valid_o,
    output logic       [`RV_XLEN-1:0] d_pc_o,
    output logic                [4:0] d_rs1_addr_o,
    output logic                [4:0] d_rs2_addr_o,
    output logic       [`RV_XLEN-1:0] d_rs1_data_o,
    output logic       [`RV_XLEN-1:0] d_rs2_data_o,
    output logic       [`RV_XLEN-1:0] d_imm_o,
    output logic                [4:0] d_rd_o,
    output logic                      d_wen_o,
    output rv_core_pkg::alu_op_e      d_alu_op_o,
    output rv_core_pkg::src_a_e       d_src_a_o,
    output rv_core_pkg::src_b_e       d_src_b_o,
    output rv_core_pkg::br_cond_e     d_br_o
);
    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0] imm_i, imm_u, imm_b, imm_j, imm;
    alu_op_e             alu_op;
    src_a_e              src_a;
    src_b_e              src_b;
    br_cond_e            br;
    logic                wen;

    // SUB only exists in the register form
    function automatic alu_op_e alu_from_funct(input logic [2:0] funct3,
                                               input logic alt,
                                               input logic is_reg);
        case (funct3)
            3'b000:  return (alt && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign rs1_addr_o = f_instr_i.r_fmt.rs1;
    assign rs2_addr_o = f_instr_i.r_fmt.rs2;

    assign imm_i = {{(`RV_XLEN-12){f_instr_i.i_fmt.imm_11_0[11]}}, f_instr_i.i_fmt.imm_11_0};
    assign imm_u = {f_instr_i.u_fmt.imm_31_12, 12'b0};
    assign imm_b = {{(`RV_XLEN-12){f_instr_i.b_fmt.imm_12}}, f_instr_i.b_fmt.imm_11,
                    f_instr_i.b_fmt.imm_10_5, f_instr_i.b_fmt.imm_4_1, 1'b0};
    assign imm_j = {{(`RV_XLEN-20){f_instr_i.j_fmt.imm_20}}, f_instr_i.j_fmt.imm_19_12,
                    f_instr_i.j_fmt.imm_11, f_instr_i.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        alu_op = alu_from_funct(f_instr_i.r_fmt.funct3, f_instr_i.r_fmt.funct7[5],
                                f_instr_i.r_fmt.opcode[5]);
        src_a  = SRC_A_RS1;
        src_b  = SRC_B_IMM;
        br     = BR_NONE;
        wen    = 1'b1;
        imm    = imm_i;
        case (f_instr_i.r_fmt.opcode)
            7'b0110011: src_b = SRC_B_RS2;
            7'b0010011: ;
            // LUI
            7'b0110111: begin
                alu_op = ALU_ADD;
                src_a  = SRC_A_ZERO;
                imm    = imm_u;
            end
            // AUIPC
            7'b0010111: begin
                alu_op = ALU_ADD;
                src_a  = SRC_A_PC;
                imm    = imm_u;
            end
            7'b1100011: begin
                src_b = SRC_B_RS2;
                wen   = 1'b0;
                imm   = imm_b;
                case (f_instr_i.b_fmt.funct3)
                    3'b000:  br = BR_EQ;
                    3'b001:  br = BR_NE;
                    3'b100:  br = BR_LT;
                    3'b101:  br = BR_GE;
                    3'b110:  br = BR_LTU;
                    3'b111:  br = BR_GEU;
                    default: br = BR_NONE;
                endcase
            end
            7'b1101111: begin
                br  = BR_JAL;
                imm = imm_j;
            end
            7'b1100111: br = BR_JALR;
            // Unknown opcodes pass through as no-ops
            default: wen = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            d_valid_o <= 1'b0;
            d_wen_o   <= 1'b0;
            d_br_o    <= BR_NONE;
        end else if (flush_i) begin
            d_valid_o <= 1'b0;
            d_wen_o   <= 1'b0;
            d_br_o    <= BR_NONE;
        end else begin
            d_valid_o <= f_valid_i;
            d_wen_o   <= wen;
            d_br_o    <= br;
        end
    end

    always_ff @(posedge clk) begin
        d_pc_o       <= f_pc_i;
        d_rs1_addr_o <= f_instr_i.r_fmt.rs1;
        d_rs2_addr_o <= f_instr_i.r_fmt.rs2;
        d_rs1_data_o <= rs1_data_i;
        d_rs2_data_o <= rs2_data_i;
        d_imm_o      <= imm;
        d_rd_o       <= f_instr_i.r_fmt.rd;
        d_alu_op_o   <= alu_op;
        d_src_a_o    <= src_a;
        d_src_b_o    <= src_b;
    end

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module fetch_unit (
    input  wire logic                clk,
    input  wire logic                rst_n_i,
    input  wire logic                redirect_i,
    input  wire logic [`RV_XLEN-1:0] target_i,
    output logic      [`RV_XLEN-1:0] imem_addr_o,
    input  wire rv_core_pkg::instr_u imem_data_i,
    output logic                     f_valid_o,
    output logic      [`RV_XLEN-1:0] f_pc_o,
    output rv_core_pkg::instr_u      f_instr_o
);
    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0] pc_q;

    // Instruction port answers in the same cycle
    assign imem_addr_o = pc_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q      <= `RV_RESET_PC;
            f_valid_o <= 1'b0;
        end else if (redirect_i) begin
            pc_q      <= target_i;
            f_valid_o <= 1'b0;
        end else begin
            pc_q      <= pc_q + 4;
            f_valid_o <= 1'b1;
        end
    end

    // Word on the port is dropped when a jump is taken
    always_ff @(posedge clk) begin
        f_pc_o <= pc_q;
        if (redirect_i) begin
            f_instr_o <= instr_u'(`RV_NOP);
        end else begin
            f_instr_o <= imem_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== rv_core_pkg.sv ====
`default_nettype none

`include "rv_core_cfg.svh"

package rv_core_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    // Upper immediate sits in the top bits of the word
    typedef struct packed {
        logic [`RV_XLEN-1:12] imm_31_12;
        logic [4:0]           rd;
        logic [6:0]           opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE,
        BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } br_cond_e;

    typedef enum logic [1:0] {
        SRC_A_RS1, SRC_A_PC, SRC_A_ZERO
    } src_a_e;

    typedef enum logic {
        SRC_B_RS2, SRC_B_IMM
    } src_b_e;

endpackage

`default_nettype wire

// ==== rv_core_cfg.svh ====
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Program counter after reset
`define RV_RESET_PC 32'h0000_0000

// ADDI x0, x0, 0
`define RV_NOP 32'h0000_0013

// Architectural integer registers, x0 included
`define RV_NREGS 32

// Data and address width
`define RV_XLEN 32

`endif
